/* source/router_macros.svh */
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// Stream word width
`define ROUTER_DATA_W     32
// Output ports and the width of a port number
`define ROUTER_NUM_PORTS  4
`define ROUTER_PORT_W     2
// FIFO depths in entries
`define ROUTER_PRE_DEPTH  4
`define ROUTER_POST_DEPTH 8
// Header rule, destination field is header bits 31:30
`define ROUTER_DEST_MSB   31

`endif

/* source/router_pkg.sv */
`include "router_macros.svh"

// Shared types of the packet router
package router_pkg;

  // One stream word
  typedef logic [`ROUTER_DATA_W-1:0]    data_t;

  // Output port number, as carried in the header
  typedef logic [`ROUTER_PORT_W-1:0]    port_t;

  // One-hot set of selected output ports
  typedef logic [`ROUTER_NUM_PORTS-1:0] port_mask_t;

endpackage

/* source/stream_fifo.sv */
`timescale 1ns/1ps

// Synchronous valid/ready FIFO
// Head word sits in an output register, so o_data comes straight from a flop
module stream_fifo #(
  parameter int WIDTH = 33,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             i_rst,
  input  logic             i_clear,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_write;
  logic do_read;
  logic load_out;
  logic bypass;
  logic push;
  logic pop;

  // --------------------------------------------------------------------------
  // Handshake decode
  // --------------------------------------------------------------------------

  // Accept while the buffer behind the output register has room
  assign o_ready  = (count != FULL_CNT);
  assign do_write = i_valid & o_ready;
  assign do_read  = o_valid & i_ready;
  // Output register refills when it is empty or being read
  assign load_out = ~o_valid | do_read;
  // Nothing buffered, incoming word goes straight to the output
  assign bypass   = do_write & load_out & (count == '0);
  assign push     = do_write & ~bypass;
  assign pop      = load_out & (count != '0);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Oldest buffered word wins over the bypass path
  always_ff @(posedge clk) begin
    if (pop) begin
      o_data <= mem[rd_ptr];
    end else if (bypass) begin
      o_data <= i_data;
    end
  end

  // Pointers, occupancy and output valid
  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
      if (load_out) begin
        o_valid <= pop | bypass;
      end
    end
  end

endmodule

/* source/packet_demux.sv */
`timescale 1ns/1ps

`include "router_macros.svh"

// One-to-four packet demultiplexer
// Output port changes only between packets, one bubble cycle per switch
module packet_demux (
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic                   i_clear,

  // Header tap, destination comes back from the top
  output router_pkg::data_t      o_header,
  input  router_pkg::port_t      i_dest,

  // Input stream
  input  router_pkg::data_t      i_data,
  input  logic                   i_last,
  input  logic                   i_valid,
  output logic                   o_ready,

  // Output streams, data and last shared by all ports
  output router_pkg::data_t      o_data,
  output logic                   o_last,
  output router_pkg::port_mask_t o_valid,
  input  router_pkg::port_mask_t i_ready
);

  // One-hot selection, all zero while between packets
  router_pkg::port_mask_t sel;

  logic idle;
  logic xfer;
  logic pkt_end;

  // --------------------------------------------------------------------------
  // Selection state
  // --------------------------------------------------------------------------

  assign idle    = (sel == '0);
  assign xfer    = i_valid & o_ready;
  // Final word of the packet leaves on this edge
  assign pkt_end = xfer & i_last;

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      sel <= '0;
    end else if (idle) begin
      // Bubble cycle, latch the port of the waiting header word
      if (i_valid) begin
        sel[i_dest] <= 1'b1;
      end
    end else if (pkt_end) begin
      sel <= '0;
    end
  end

  // --------------------------------------------------------------------------
  // Steering
  // --------------------------------------------------------------------------

  // While idle the head word is the header
  assign o_header = i_data;

  // Word fans out to every port, only one of them sees valid
  assign o_data   = i_data;
  assign o_last   = i_last;
  assign o_valid  = {`ROUTER_NUM_PORTS{i_valid}} & sel;

  // Ready of the selected port only
  // Low while idle, so nothing passes in the bubble cycle
  assign o_ready  = |(i_ready & sel);

endmodule

/* source/pkt_router.sv */
`timescale 1ns/1ps

`include "router_macros.svh"

// Packet router, one input stream to four output streams
// Input FIFO, then the demultiplexer, then one FIFO per output port
module pkt_router (
  input  logic                                         clk,
  input  logic                                         i_rst,
  input  logic                                         i_clear,

  // Source side
  input  router_pkg::data_t                            i_data,
  input  logic                                         i_last,
  input  logic                                         i_valid,
  output logic                                         o_ready,

  // Consumer side, one lane per port
  output router_pkg::data_t [`ROUTER_NUM_PORTS-1:0]    o_data,
  output logic              [`ROUTER_NUM_PORTS-1:0]    o_last,
  output router_pkg::port_mask_t                       o_valid,
  input  router_pkg::port_mask_t                       i_ready
);

  // Input FIFO to demultiplexer
  router_pkg::data_t      pre_data;
  logic                   pre_last;
  logic                   pre_valid;
  logic                   pre_ready;

  // Header tap and destination field
  router_pkg::data_t      header;
  router_pkg::port_t      dest;

  // Demultiplexer to output FIFOs
  router_pkg::data_t      dmx_data;
  logic                   dmx_last;
  router_pkg::port_mask_t dmx_valid;
  router_pkg::port_mask_t post_ready;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------

  // Last bit rides along with the word
  stream_fifo #(
    .WIDTH (`ROUTER_DATA_W + 1),
    .DEPTH (`ROUTER_PRE_DEPTH)
  ) pre_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .i_data  ({i_last, i_data}),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_data  ({pre_last, pre_data}),
    .o_valid (pre_valid),
    .i_ready (pre_ready)
  );

  // Top two header bits name the port
  assign dest = header[`ROUTER_DEST_MSB -: `ROUTER_PORT_W];

  packet_demux demux0 (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_clear  (i_clear),
    .o_header (header),
    .i_dest   (dest),
    .i_data   (pre_data),
    .i_last   (pre_last),
    .i_valid  (pre_valid),
    .o_ready  (pre_ready),
    .o_data   (dmx_data),
    .o_last   (dmx_last),
    .o_valid  (dmx_valid),
    .i_ready  (post_ready)
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------

  // Each port buffers on its own so a stalled consumer blocks only its packets
  for (genvar n = 0; n < `ROUTER_NUM_PORTS; n++) begin : post_fifo
    stream_fifo #(
      .WIDTH (`ROUTER_DATA_W + 1),
      .DEPTH (`ROUTER_POST_DEPTH)
    ) fifo (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (i_clear),
      .i_data  ({dmx_last, dmx_data}),
      .i_valid (dmx_valid[n]),
      .o_ready (post_ready[n]),
      .o_data  ({o_last[n], o_data[n]}),
      .o_valid (o_valid[n]),
      .i_ready (i_ready[n])
    );
  end

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

// Free running 10 ns clock and a reset held for the first 4 rising edges
module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (4) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

/* tb/pkt_router_sva.sv */
`timescale 1ns/1ps

`include "router_macros.svh"

// Handshake and selection invariants of the packet router
module pkt_router_sva (
  input logic                                      clk,
  input logic                                      i_rst,
  input logic                                      i_clear,
  input router_pkg::port_mask_t                    i_dmx_valid,
  input router_pkg::data_t [`ROUTER_NUM_PORTS-1:0] i_data,
  input logic [`ROUTER_NUM_PORTS-1:0]              i_last,
  input router_pkg::port_mask_t                    i_valid,
  input router_pkg::port_mask_t                    i_ready
);

  // Demux steers each word to one port at most
  a_single_port: assert property (@(posedge clk) disable iff (i_rst)
    $onehot0(i_dmx_valid))
    else $error("demux raised valid on more than one port");

  // Outputs come up idle right after reset
  a_idle_after_reset: assert property (@(posedge clk)
    i_rst |=> (i_valid == '0))
    else $error("output valid high in the cycle after reset");

  // ------------------------------------------------------------------------
  // Per-port stability while stalled
  // ------------------------------------------------------------------------

  for (genvar n = 0; n < `ROUTER_NUM_PORTS; n++) begin : port_chk
    // A clear may drop the held word, so it is left out of the trigger
    a_hold: assert property (@(posedge clk) disable iff (i_rst)
      (i_valid[n] && !i_ready[n] && !i_clear) |=>
        (i_valid[n] && $stable(i_data[n]) && $stable(i_last[n])))
      else $error("port %0d changed a held word before ready", n);
  end

endmodule

/* tb/tb_pkt_router.sv */
`timescale 1ns/1ps

`include "router_macros.svh"

module tb_pkt_router;

  localparam int NPORTS     = `ROUTER_NUM_PORTS;
  localparam int STIM_MAX   = 64;
  localparam int WAIT_LIMIT = 200;

  // Record kinds in the top hex digit of each stim line
  localparam logic [3:0] KIND_WORD  = 4'h0;
  localparam logic [3:0] KIND_LAST  = 4'h1;
  localparam logic [3:0] KIND_CLEAR = 4'h2;
  localparam logic [3:0] KIND_END   = 4'h3;

  logic                           clk;
  logic                           i_rst;
  logic                           i_clear;
  router_pkg::data_t              i_data;
  logic                           i_last;
  logic                           i_valid;
  logic                           o_ready;
  router_pkg::data_t [NPORTS-1:0] o_data;
  logic [NPORTS-1:0]              o_last;
  router_pkg::port_mask_t         o_valid;
  router_pkg::port_mask_t         i_ready;

  logic [35:0]       stim_mem [STIM_MAX];
  // Expected {last, data} per output port with the oldest word first
  logic [32:0]       exp_q [NPORTS][$];
  integer            seed;
  int                rnd;
  int                wait_cnt;
  int                rec_idx;
  logic              stim_done;
  logic [3:0]        kind;
  // Model state of the packet being sent
  logic              in_pkt;
  router_pkg::port_t cur_port;

  tb_clkgen clkgen0 (
    .o_clk (clk),
    .o_rst (i_rst)
  );

  pkt_router dut0 (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .i_data  (i_data),
    .i_last  (i_last),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_data  (o_data),
    .o_last  (o_last),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

  bind pkt_router pkt_router_sva sva0 (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .i_dmx_valid (dmx_valid),
    .i_data      (o_data),
    .i_last      (o_last),
    .i_valid     (o_valid),
    .i_ready     (i_ready)
  );

  // --------------------------------------------------------------------------
  // Checking helpers
  // --------------------------------------------------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    end
  endtask

  // Words the model still expects on all ports together
  function automatic int pending_words();
    int total;
    total = 0;
    for (int n = 0; n < NPORTS; n++) begin
      total += exp_q[n].size();
    end
    return total;
  endfunction

  // Check the transfers that the coming rising edge completes against the model
  task automatic check_outputs();
    logic [32:0] expected;
    for (int n = 0; n < NPORTS; n++) begin
      if (o_valid[n] && i_ready[n]) begin
        if (exp_q[n].size() == 0) begin
          report_failure($sformatf("Port %0d delivered a word that no packet sent", n));
        end else begin
          expected = exp_q[n].pop_front();
          check_value($sformatf("o_data[%0d]", n), 64'(o_data[n]), 64'(expected[31:0]));
          check_value($sformatf("o_last[%0d]", n), 64'(o_last[n]), 64'(expected[32]));
        end
      end
    end
  endtask

  // Step to the falling edge and draw a fresh consumer ready
  // About 3 in 4 ready bits come out high
  task automatic next_cycle();
    @(negedge clk);
    rnd     = $random(seed);
    i_ready = rnd[3:0] | rnd[7:4];
    check_outputs();
  endtask

  // --------------------------------------------------------------------------
  // Driving and model
  // --------------------------------------------------------------------------

  // Header of each packet picks the queue for all its words
  // Destination is header bits 31:30
  task automatic record_word();
    if (!in_pkt) begin
      cur_port = i_data[31:30];
      in_pkt   = 1'b1;
    end
    exp_q[cur_port].push_back({i_last, i_data});
    if (i_last) begin
      in_pkt = 1'b0;
    end
  endtask

  task automatic send_word(input router_pkg::data_t data, input logic last);
    i_data   = data;
    i_last   = last;
    i_valid  = 1'b1;
    wait_cnt = 0;
    // o_ready is registered, so its value here holds for the next edge
    while (!o_ready) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        report_failure("Timed out waiting for the router to accept a word");
      end
    end
    record_word();
    next_cycle();
    i_valid = 1'b0;
  endtask

  // All in-flight words vanish with the clear
  task automatic send_clear();
    i_clear = 1'b1;
    i_valid = 1'b0;
    for (int n = 0; n < NPORTS; n++) begin
      exp_q[n].delete();
    end
    in_pkt = 1'b0;
    next_cycle();
    i_clear = 1'b0;
  endtask

  initial begin
    seed      = 66;
    i_clear   = 1'b0;
    i_data    = '0;
    i_last    = 1'b0;
    i_valid   = 1'b0;
    i_ready   = '0;
    in_pkt    = 1'b0;
    cur_port  = '0;
    stim_done = 1'b0;
    $readmemh("tb/pkt_router_stim.txt", stim_mem);

    // Hold off until reset is released
    wait_cnt = 0;
    next_cycle();
    while (i_rst) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        report_failure("Timed out waiting for reset to be released");
      end
    end
    check_value("o_valid", 64'(o_valid), 64'(0));

    // One stim record per pass
    rec_idx = 0;
    while (!stim_done && rec_idx < STIM_MAX) begin
      kind = stim_mem[rec_idx][35:32];
      case (kind)
        KIND_WORD:  send_word(stim_mem[rec_idx][31:0], 1'b0);
        KIND_LAST:  send_word(stim_mem[rec_idx][31:0], 1'b1);
        KIND_CLEAR: send_clear();
        KIND_END:   stim_done = 1'b1;
        default:    report_failure("Unknown record kind in the stim file");
      endcase
      rec_idx++;
    end

    // Let every port empty its FIFO
    wait_cnt = 0;
    while (pending_words() != 0) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        report_failure("Timed out waiting for the output queues to drain");
      end
    end
    next_cycle();

    // Any valid left now is a word the model never sent
    if (o_valid == '0) begin
      $display("Test passed");
      $finish;
    end else begin
      report_failure("Words left over at the end of the stream");
    end
  end

endmodule

/* pkt_router.f */
+incdir+source
source/router_pkg.sv
source/stream_fifo.sv
source/packet_demux.sv
source/pkt_router.sv
tb/tb_clkgen.sv
tb/pkt_router_sva.sv
tb/tb_pkt_router.sv

/* run.sh */
#!/bin/sh
# Build the packet router testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module tb_pkt_router -f pkt_router.f -o sim_pkt_router || exit 1
sim_out=$(./obj_dir/sim_pkt_router 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Test passed" && exit 0 || exit 1

/* tb/pkt_router_stim.txt */
// Kind digit then eight data digits, header port in data bits 31:30
// Kind 0 word, 1 last word, 2 clear all FIFOs, 3 end of stimulus
0C00000A0
0000000A1
1000000A2
0000000B0
1123400B1
1400000C0
0C00000D0
1FFFF00D1
080000E00
0DEADBEEF
00000E002
10000E003
0000000E4
1C00000E5
200000000
0800000F0
1000000F1
0400000A5
055AA55AA
1400000A7
000000C30
1C0000C31
0C0000D00
10000D001
180000F00
300000000
